//--- verilog/icache_pkg.sv
`default_nettype none

package icache_pkg;

    localparam int addr_w = 32;
    localparam int line_words = 8;
    localparam int fetch_words = 4;
    localparam int offset_w = 3;
    localparam int line_addr_w = addr_w - offset_w - 2; // Byte offset inside the line dropped.
    localparam int index_max_w = 8;

    typedef struct packed {
        logic [addr_w-1:0] pc;
        logic [2:0]        count; // 1 to 4 words.
    } fetch_req_t;

    typedef struct packed {
        logic [addr_w-1:0]                 pc;
        logic [fetch_words-1:0][31:0]      words; // Slot 0 holds the word at pc.
        logic [fetch_words-1:0]            mask;
    } fetch_pkt_t;

    typedef struct packed {
        logic [line_addr_w-1:0] line_addr;
        logic                   way; // Victim way.
    } refill_req_t;

    // One word written into the arrays by the refill engine.
    typedef struct packed {
        logic                   en;
        logic                   way;
        logic [index_max_w-1:0] index; // Only the low index bits are used.
        logic [offset_w-1:0]    word;
        logic [31:0]            data;
        logic                   set_valid; // Last word of the line.
        logic [line_addr_w-1:0] line_addr; // Tag bits of the line come from here.
    } array_wr_t;

    typedef enum logic [1:0] {
        LK_IDLE,
        LK_CHECK,
        LK_WAIT_REFILL,
        LK_HOLD
    } lookup_state_t;

    typedef enum logic [1:0] {
        RF_IDLE,
        RF_BUS,
        RF_DONE
    } refill_state_t;

endpackage

`default_nettype wire

//--- verilog/icache_req_stage.sv
`default_nettype none

module icache_req_stage #(
    parameter int num_sets = 16,
    localparam int index_w = $clog2(num_sets)
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         flush,
    input  wire                         req_valid,
    input  wire icache_pkg::fetch_req_t req,
    output logic                        req_ready,
    input  wire                         s1_ready,
    output logic                        s1_valid,
    output icache_pkg::fetch_req_t      s1_req,
    output logic                        rd_en,
    output logic [index_w-1:0]          rd_index
);
    import icache_pkg::*;

    logic                accept;
    logic                alive;
    logic [offset_w-1:0] word_off;
    logic [offset_w:0]   room;
    fetch_req_t          clamped;

    // s1_ready is high only when the lookup stage can take s1 this cycle,
    // so the stage is either empty or emptying whenever it is high.
    assign req_ready = alive && !flush && s1_ready;
    assign accept = req_valid && req_ready;

    assign rd_en = accept; // Array read starts with the accept.
    assign rd_index = req.pc[offset_w+2 +: index_w];

    assign word_off = req.pc[offset_w+1:2];
    assign room = (offset_w+1)'(line_words) - {1'b0, word_off};

    // Cut the fetch at the line end.
    always_comb begin
        clamped = req;
        if (room < {1'b0, req.count}) begin
            clamped.count = room[2:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alive <= 1'b0;
            s1_valid <= 1'b0;
        end else begin
            alive <= 1'b1;
            if (flush) begin
                s1_valid <= 1'b0;
            end else if (accept) begin
                s1_valid <= 1'b1;
            end else if (s1_ready) begin
                s1_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_req <= clamped;
        end
    end

    // A request stalled by the lookup stage is neither lost nor overwritten.
    a_s1_held: assert property (@(posedge clk) disable iff (!rst_n)
        s1_valid && !s1_ready && !flush |=> s1_valid && $stable(s1_req));

endmodule

`default_nettype wire

//--- verilog/icache_way_array.sv
`default_nettype none

module icache_way_array #(
    parameter int num_sets = 16,
    localparam int index_w = $clog2(num_sets),
    localparam int tag_w = icache_pkg::addr_w - index_w - icache_pkg::offset_w - 2
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        rd_en,
    input  wire [index_w-1:0]          rd_index,
    input  wire                        replay_en,
    input  wire [index_w-1:0]          replay_index,
    input  wire icache_pkg::array_wr_t wr,
    output logic [1:0][tag_w-1:0]      tag_q,
    output logic [1:0]                 valid_q,
    output logic [1:0][icache_pkg::line_words-1:0][31:0] line_q
);
    import icache_pkg::*;

    logic [tag_w-1:0]    tag_mem [2][num_sets];
    logic [31:0]         data_mem [2][line_words][num_sets];
    logic [num_sets-1:0] valid_mem [2];

    logic                rd_any;
    logic [index_w-1:0]  rd_addr;
    logic [index_w-1:0]  wr_index;
    logic [tag_w-1:0]    wr_tag;

    assign rd_any = rd_en || replay_en;
    assign rd_addr = rd_en ? rd_index : replay_index;
    assign wr_index = wr.index[index_w-1:0];
    assign wr_tag = wr.line_addr[line_addr_w-1 -: tag_w];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            tag_mem[wr.way][wr_index] <= wr_tag;
            data_mem[wr.way][wr.word][wr_index] <= wr.data;
        end
    end

    // Word 0 drops the old line, the last word makes the new one valid.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_mem[0] <= '0;
            valid_mem[1] <= '0;
        end else if (wr.en) begin
            if (wr.set_valid) begin
                valid_mem[wr.way][wr_index] <= 1'b1;
            end else if (wr.word == '0) begin
                valid_mem[wr.way][wr_index] <= 1'b0;
            end
        end
    end

    // Outputs hold the last read until the next one.
    always_ff @(posedge clk) begin
        if (rd_any) begin
            for (int w = 0; w < 2; w++) begin
                tag_q[w] <= tag_mem[w][rd_addr];
                valid_q[w] <= valid_mem[w][rd_addr];
                for (int b = 0; b < line_words; b++) begin
                    line_q[w][b] <= data_mem[w][b][rd_addr];
                end
            end
        end
    end

    // The request stage must stay out while the lookup stage replays.
    a_one_reader: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd_en && replay_en));

endmodule

`default_nettype wire

//--- verilog/icache_lookup_stage.sv
`default_nettype none

module icache_lookup_stage #(
    parameter int num_sets = 16,
    localparam int index_w = $clog2(num_sets),
    localparam int tag_w = icache_pkg::addr_w - index_w - icache_pkg::offset_w - 2
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          flush,
    input  wire                          s1_valid,
    input  wire icache_pkg::fetch_req_t  s1_req,
    output logic                         s1_ready,
    input  wire [1:0][tag_w-1:0]         tag_q,
    input  wire [1:0]                    valid_q,
    input  wire [1:0][icache_pkg::line_words-1:0][31:0] line_q,
    output logic                         replay_en,
    output logic [index_w-1:0]           replay_index,
    output logic                         refill_valid,
    output icache_pkg::refill_req_t      refill_req,
    input  wire                          refill_done,
    output logic                         resp_valid,
    input  wire                          resp_ready,
    output icache_pkg::fetch_pkt_t       resp
);
    import icache_pkg::*;

    lookup_state_t       state;
    fetch_req_t          lk_req; // Request waiting on a refill.
    logic                lk_flushed;
    logic [num_sets-1:0] lru; // Points at the least recently used way.

    fetch_req_t          cur_req;
    logic [index_w-1:0]  cur_index;
    logic [tag_w-1:0]    cur_tag;
    logic [offset_w-1:0] cur_off;
    logic [1:0]          hit;
    logic                hit_way;
    logic                victim;
    logic                take;
    logic                load_resp;
    logic                start_refill;
    fetch_pkt_t          pkt;

    assign cur_req = (state == LK_CHECK) ? lk_req : s1_req;
    assign cur_index = cur_req.pc[offset_w+2 +: index_w];
    assign cur_tag = cur_req.pc[addr_w-1 -: tag_w];
    assign cur_off = cur_req.pc[offset_w+1:2];

    assign hit[0] = valid_q[0] && (tag_q[0] == cur_tag);
    assign hit[1] = valid_q[1] && (tag_q[1] == cur_tag);
    assign hit_way = hit[1];
    assign victim = !valid_q[0] ? 1'b0 : (!valid_q[1] ? 1'b1 : lru[cur_index]);

    assign s1_ready = (state == LK_IDLE) || (state == LK_HOLD && resp_ready);
    assign take = (s1_valid && s1_ready) || state == LK_CHECK;
    assign load_resp = take && (|hit) && !flush;
    // A flushed miss still refills so the line is there next time.
    assign start_refill = take && !(|hit) && !(flush && state == LK_CHECK);

    // Replay the missed line, then restore the read of whatever waits in s1.
    assign replay_en = (state == LK_WAIT_REFILL && refill_done && !lk_flushed && !flush) ||
                       (state == LK_CHECK && s1_valid);
    assign replay_index = (state == LK_CHECK) ? s1_req.pc[offset_w+2 +: index_w] :
                                                lk_req.pc[offset_w+2 +: index_w];

    always_comb begin
        logic [offset_w-1:0] slot;
        pkt.pc = cur_req.pc;
        for (int i = 0; i < fetch_words; i++) begin
            slot = cur_off + offset_w'(i);
            pkt.mask[i] = (i < cur_req.count);
            pkt.words[i] = pkt.mask[i] ? line_q[hit_way][slot] : 32'h0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= LK_IDLE;
            resp_valid <= 1'b0;
            refill_valid <= 1'b0;
            lk_flushed <= 1'b0;
            lru <= '0;
        end else begin
            refill_valid <= start_refill;
            if (start_refill) begin
                lk_flushed <= flush;
            end else if (flush) begin
                lk_flushed <= 1'b1;
            end
            case (state)
                LK_IDLE, LK_HOLD: begin
                    if (s1_ready || flush) begin
                        resp_valid <= 1'b0;
                        state <= LK_IDLE;
                    end
                end
                LK_WAIT_REFILL: begin
                    if (refill_done) begin
                        state <= (lk_flushed || flush) ? LK_IDLE : LK_CHECK;
                    end
                end
                default: state <= LK_IDLE;
            endcase
            if (load_resp) begin
                resp_valid <= 1'b1;
                lru[cur_index] <= ~hit_way;
                state <= LK_HOLD;
            end
            if (start_refill) begin
                state <= LK_WAIT_REFILL;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_resp) begin
            resp <= pkt;
        end
        if (start_refill) begin
            lk_req <= cur_req;
            refill_req.line_addr <= cur_req.pc[addr_w-1 -: line_addr_w];
            refill_req.way <= victim;
        end
    end

    a_resp_held: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> $stable(resp));

endmodule

`default_nettype wire

//--- verilog/icache_refill.sv
`default_nettype none

module icache_refill (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          refill_valid,
    input  wire icache_pkg::refill_req_t refill_req,
    output logic                         refill_done,
    output icache_pkg::array_wr_t        wr,
    output logic                         wb_cyc,
    output logic                         wb_stb,
    output logic [31:0]                  wb_adr,
    input  wire [31:0]                   wb_dat_i,
    input  wire                          wb_ack
);
    import icache_pkg::*;

    localparam logic [offset_w-1:0] last_word = offset_w'(line_words - 1);

    refill_state_t       state;
    refill_req_t         cur;
    logic [offset_w-1:0] word_cnt;
    logic                take_word;

    assign take_word = (state == RF_BUS) && wb_stb && wb_ack;
    assign refill_done = (state == RF_DONE); // One cycle after the last ack.
    assign wb_adr = {cur.line_addr, word_cnt, 2'b00};

    // Every acked word goes straight into the chosen way.
    always_comb begin
        wr.en = take_word;
        wr.way = cur.way;
        wr.index = cur.line_addr[index_max_w-1:0];
        wr.word = word_cnt;
        wr.data = wb_dat_i;
        wr.set_valid = take_word && (word_cnt == last_word);
        wr.line_addr = cur.line_addr;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= RF_IDLE;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            word_cnt <= '0;
        end else begin
            case (state)
                RF_IDLE: begin
                    if (refill_valid) begin
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        word_cnt <= '0;
                        state <= RF_BUS;
                    end
                end
                RF_BUS: begin
                    if (take_word) begin
                        wb_stb <= 1'b0; // One idle cycle between words.
                        if (word_cnt == last_word) begin
                            wb_cyc <= 1'b0;
                            state <= RF_DONE;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                        end
                    end else if (!wb_stb) begin
                        wb_stb <= 1'b1;
                    end
                end
                default: state <= RF_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RF_IDLE && refill_valid) begin
            cur <= refill_req;
        end
    end

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb |-> wb_cyc);

    a_adr_held: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr));

endmodule

`default_nettype wire

//--- verilog/icache_top.sv
`default_nettype none

module icache_top #(
    parameter int num_sets = 16,
    localparam int index_w = $clog2(num_sets),
    localparam int tag_w = icache_pkg::addr_w - index_w - icache_pkg::offset_w - 2
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         req_valid,
    output wire                         req_ready,
    input  wire icache_pkg::fetch_req_t req,
    output wire                         resp_valid,
    input  wire                         resp_ready,
    output wire icache_pkg::fetch_pkt_t resp,
    input  wire                         flush,
    output wire                         wb_cyc,
    output wire                         wb_stb,
    output wire                         wb_we,
    output wire [31:0]                  wb_adr,
    output wire [3:0]                   wb_sel,
    input  wire [31:0]                  wb_dat_i,
    input  wire                         wb_ack
);
    import icache_pkg::*;

    wire                 s1_valid;
    wire                 s1_ready;
    fetch_req_t          s1_req;
    wire                 rd_en;
    wire [index_w-1:0]   rd_index;
    wire                 replay_en;
    wire [index_w-1:0]   replay_index;
    wire [1:0][tag_w-1:0] tag_q;
    wire [1:0]           valid_q;
    wire [1:0][line_words-1:0][31:0] line_q;
    wire                 refill_valid;
    refill_req_t         refill_req;
    wire                 refill_done;
    array_wr_t           wr;

    assign wb_we = 1'b0; // Read only.
    assign wb_sel = 4'hf;

    icache_req_stage #(.num_sets(num_sets)) req_stage_i (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .req_valid(req_valid), .req(req), .req_ready(req_ready),
        .s1_ready(s1_ready), .s1_valid(s1_valid), .s1_req(s1_req),
        .rd_en(rd_en), .rd_index(rd_index)
    );

    icache_way_array #(.num_sets(num_sets)) way_array_i (
        .clk(clk), .rst_n(rst_n),
        .rd_en(rd_en), .rd_index(rd_index),
        .replay_en(replay_en), .replay_index(replay_index), .wr(wr),
        .tag_q(tag_q), .valid_q(valid_q), .line_q(line_q)
    );

    icache_lookup_stage #(.num_sets(num_sets)) lookup_stage_i (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .s1_valid(s1_valid), .s1_req(s1_req), .s1_ready(s1_ready),
        .tag_q(tag_q), .valid_q(valid_q), .line_q(line_q),
        .replay_en(replay_en), .replay_index(replay_index),
        .refill_valid(refill_valid), .refill_req(refill_req), .refill_done(refill_done),
        .resp_valid(resp_valid), .resp_ready(resp_ready), .resp(resp)
    );

    icache_refill refill_i (
        .clk(clk), .rst_n(rst_n),
        .refill_valid(refill_valid), .refill_req(refill_req), .refill_done(refill_done),
        .wr(wr),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
    );

endmodule

`default_nettype wire

//--- tests/icache_tb.sv
`default_nettype none

module icache_tb;
    import icache_pkg::*;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        req_valid;
    fetch_req_t  req;
    wire         req_ready;
    wire         resp_valid;
    logic        resp_ready;
    wire fetch_pkt_t resp;
    logic        flush;
    wire         wb_cyc;
    wire         wb_stb;
    wire         wb_we;
    wire [31:0]  wb_adr;
    wire [3:0]   wb_sel;
    logic [31:0] wb_dat_i;
    logic        wb_ack;

    // Stimulus table, one entry per row.
    string       names [32];
    logic [31:0] pcs [32];
    logic [2:0]  counts [32];
    bit          flush_after [32];
    bit          rand_rows [32];
    int          refills [32];
    logic [3:0]  masks [32];
    int          acks [32]; // Wishbone reads seen for each row.
    int          num_rows = 0;

    int          exp_rows [$]; // Rows still owed a response, in request order.
    int          flush_row = -1; // Row whose response was flushed away.
    int          errors = 0;
    int          resp_count = 0;
    int          ack_wait = 0;
    int          cycles = 0;
    logic [31:0] lfsr = 32'hf5b9_d96f;
    string       cur_name = "reset";
    bit          rand_ready = 1'b0;

    icache_top #(.num_sets(16)) icache_top_i (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .resp_valid(resp_valid), .resp_ready(resp_ready), .resp(resp),
        .flush(flush),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_sel(wb_sel), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1.
    endfunction

    task automatic draw_bits(input int n, output logic [3:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[2:0], lfsr[0]};
        end
    endtask

    // Memory content rule.
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return (a ^ 32'h5a5a_0000) + a;
    endfunction

    // Oldest fetch in flight whose line holds this address, or -1.
    function automatic int line_owner(input logic [31:0] adr);
        foreach (exp_rows[i]) begin
            if (((pcs[exp_rows[i]] ^ adr) & 32'hffff_ffe0) == 32'h0) begin
                return exp_rows[i];
            end
        end
        if (flush_row >= 0 && ((pcs[flush_row] ^ adr) & 32'hffff_ffe0) == 32'h0) begin
            return flush_row;
        end
        return -1;
    endfunction

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error: %s expected %h actual %h", what, expected, actual);
            errors++;
        end
    endtask

    task automatic add_row(input string name, input logic [31:0] pc, input int count,
                           input bit fl, input bit rr, input int words, input logic [3:0] mask);
        names[num_rows] = name;
        pcs[num_rows] = pc;
        counts[num_rows] = count[2:0];
        flush_after[num_rows] = fl;
        rand_rows[num_rows] = rr;
        refills[num_rows] = words;
        masks[num_rows] = mask;
        num_rows++;
    endtask

    task automatic load_table();
        add_row("cold_miss",        32'h0000_1004, 3, 0, 0, 8, 4'b0111);
        add_row("hit_new_offset",   32'h0000_1010, 4, 0, 0, 0, 4'b1111);
        add_row("line_end",         32'h0000_2038, 4, 0, 0, 8, 4'b0011);
        // Set 3 holds A, B and C in turn.
        add_row("repl_a",           32'h0000_0060, 1, 0, 0, 8, 4'b0001);
        add_row("repl_b",           32'h0000_026c, 2, 0, 0, 8, 4'b0011);
        add_row("repl_a_hit",       32'h0000_0070, 4, 0, 0, 0, 4'b1111);
        add_row("repl_c",           32'h0000_0460, 3, 0, 0, 8, 4'b0111);
        add_row("repl_a_kept",      32'h0000_0064, 2, 0, 0, 0, 4'b0011);
        add_row("repl_b_evicted",   32'h0000_0260, 4, 0, 0, 8, 4'b1111);
        // Issued back to back, so two fetches overlap in the pipeline.
        add_row("bp_hit",           32'h0000_1000, 4, 0, 1, 0, 4'b1111);
        add_row("bp_miss",          32'h0000_3000, 4, 0, 1, 8, 4'b1111);
        add_row("bp_hit_again",     32'h0000_3014, 2, 0, 1, 0, 4'b0011);
        add_row("bp_miss_evict",    32'h0000_4008, 3, 0, 1, 8, 4'b0111);
        add_row("bp_hit_last_word", 32'h0000_401c, 3, 0, 1, 0, 4'b0001);
        add_row("flush_miss",       32'h0000_50a0, 4, 1, 0, 8, 4'b0000);
        add_row("after_flush",      32'h0000_6024, 2, 0, 0, 8, 4'b0011);
        add_row("flushed_line_hit", 32'h0000_50a8, 4, 0, 0, 0, 4'b1111);
    endtask

    // Wishbone slave and resp_ready, driven just after the edge.
    always @(posedge clk) begin : bus_and_ready
        logic [3:0] bits;
        int owner;
        #1;
        if (rst_n) begin
            if (wb_ack) begin
                wb_ack = 1'b0; // Taken at the edge just passed.
                draw_bits(2, bits);
                ack_wait = bits;
            end else if (wb_cyc && wb_stb) begin
                if (ack_wait == 0) begin
                    owner = line_owner(wb_adr);
                    if (owner < 0) begin
                        $display("Wishbone read at %h belongs to no fetch in flight", wb_adr);
                        errors++;
                    end else begin
                        check({names[owner], " wb address"},
                              (pcs[owner] & 32'hffff_ffe0) + 4 * acks[owner], wb_adr);
                        acks[owner]++;
                    end
                    check({cur_name, " wb we and sel"}, 32'hf, {wb_we, wb_sel});
                    wb_dat_i = mem_word(wb_adr);
                    wb_ack = 1'b1;
                end else begin
                    ack_wait--;
                end
            end
            if (rand_ready) begin
                draw_bits(1, bits);
                resp_ready = bits[0];
            end else begin
                resp_ready = 1'b1;
            end
        end
    end

    // A packet seen here with ready high transfers on the next edge.
    always @(negedge clk) begin : resp_monitor
        int r;
        int n;
        if (rst_n && resp_valid && resp_ready) begin
            if (exp_rows.size() == 0) begin
                $display("Response for pc %h arrived with no request outstanding", resp.pc);
                errors++;
            end else begin
                r = exp_rows.pop_front();
                n = 8 - pcs[r][4:2];
                if (counts[r] < n) begin
                    n = counts[r];
                end
                check({names[r], " pc"}, pcs[r], resp.pc);
                check({names[r], " mask"}, masks[r], resp.mask);
                for (int i = 0; i < n; i++) begin
                    check($sformatf("%s word %0d", names[r], i),
                          mem_word(pcs[r] + 4 * i), resp.words[i]);
                end
                check({names[r], " refill words"}, refills[r], acks[r]);
                resp_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > num_rows * 200) begin
            errors++;
            $display("Timeout after %0d cycles in row %s", cycles, cur_name);
            $display("Errors: %0d, responses: %0d", errors, resp_count);
            $display("sim failed");
            $finish;
        end
    end

    task automatic run_row(input int r);
        cur_name = names[r];
        acks[r] = 0;
        rand_ready = rand_rows[r];
        if (flush_after[r]) begin
            flush_row = r;
        end else begin
            exp_rows.push_back(r);
        end
        req.pc = pcs[r];
        req.count = counts[r];
        req_valid = 1'b1;
        do begin
            @(negedge clk);
        end while (!req_ready);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        if (flush_after[r]) begin
            flush = 1'b1; // Lookup stage holds the request now.
            @(posedge clk);
            #1;
            flush = 1'b0;
            while (acks[r] < refills[r] || wb_cyc) begin
                @(negedge clk);
            end
            check({names[r], " refill words"}, refills[r], acks[r]);
            flush_row = -1;
        end else if (!(rand_rows[r] && r + 1 < num_rows && rand_rows[r + 1])) begin
            while (exp_rows.size() != 0) begin
                @(negedge clk);
            end
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        rst_n = 1'b0;
        req_valid = 1'b0;
        req = '0;
        resp_ready = 1'b1;
        flush = 1'b0;
        wb_dat_i = '0;
        wb_ack = 1'b0;
        load_table();
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
        end
        repeat (8) @(posedge clk); // Room for a stray response to show up.
        if (exp_rows.size() != 0) begin
            $display("%0d responses never arrived", exp_rows.size());
            errors++;
        end
        $display("Errors: %0d, responses: %0d", errors, resp_count);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
verilog/icache_pkg.sv
verilog/icache_req_stage.sv
verilog/icache_way_array.sv
verilog/icache_lookup_stage.sv
verilog/icache_refill.sv
verilog/icache_top.sv
tests/icache_tb.sv

//--- Bender.yml
package:
  name: icache

sources:
  - verilog/icache_pkg.sv
  - verilog/icache_req_stage.sv
  - verilog/icache_way_array.sv
  - verilog/icache_lookup_stage.sv
  - verilog/icache_refill.sv
  - verilog/icache_top.sv
  - target: test
    files:
      - tests/icache_tb.sv
